// ==== hw/life_pkg.sv ====
// ----------------------------------------------------------
// life on screen shared definitions: widths, cell word and
// the four-entry palette
// ----------------------------------------------------------
package life_pkg;

    localparam int CORDW = 8;   // signed display coordinate width
    localparam int CHANW = 4;   // bits per colour channel
    localparam int QDEPTH = 4;  // write queue depth, also the engine's starting credits

    // one cell word, seen by the engine as flags and by the framebuffer as a colour index
    typedef union packed {
        logic [1:0] cidx;       // palette index
        struct packed {
            logic changed;      // state flipped this generation
            logic alive;        // bit 0
        } flags;
    } cell_word_t;

    // 12-bit rgb, entry 3 first
    localparam logic [3:0][11:0] PALETTE = {
        12'hFFF,                // 3: born, white
        12'h600,                // 2: died, dim red
        12'h0F0,                // 1: alive, green
        12'h000                 // 0: dead, black
    };

endpackage

// ==== hw/display_timing.sv ====
// ----------------------------------------------------------
// display timing: raster counters, sync, data enable and
// the frame and line pulses
// ----------------------------------------------------------
`timescale 1ns/100ps

module display_timing #(
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL = 48,
    parameter int V_ACTIVE = 24,
    parameter int V_TOTAL = 40
) (
    input  logic clk_pix,
    input  logic rst_n,
    output logic signed [life_pkg::CORDW-1:0] sx,
    output logic signed [life_pkg::CORDW-1:0] sy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic frame,
    output logic line
);
    localparam int HS_START = H_ACTIVE + 4;  // 36..39 for the default raster
    localparam int HS_END = H_ACTIVE + 7;
    localparam int VS_START = V_ACTIVE + 4;  // 28..29
    localparam int VS_END = V_ACTIVE + 5;

    logic h_last;                           // last column of the line

    always_comb begin
        h_last = (sx == H_TOTAL - 1);
        hsync = (sx >= HS_START) && (sx <= HS_END);
        vsync = (sy >= VS_START) && (sy <= VS_END);
        de = (sx < H_ACTIVE) && (sy < V_ACTIVE);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx <= '0;
            sy <= '0;
            frame <= 1'b0;
            line <= 1'b0;
        end else begin
            frame <= h_last && (sy == V_ACTIVE - 1);  // lands on sx=0, sy=V_ACTIVE
            line <= h_last;                           // lands on sx=0
            if (h_last) begin
                sx <= '0;
                if (sy == V_TOTAL - 1) begin
                    sy <= '0;                         // wrap to top of frame
                end else begin
                    sy <= sy + 1'b1;
                end
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

endmodule

// ==== hw/gen_scheduler.sv ====
// ----------------------------------------------------------
// generation scheduler: counts frames and kicks the engine
// ----------------------------------------------------------
`timescale 1ns/100ps

module gen_scheduler #(
    parameter int GEN_FRAMES = 3
) (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic frame,
    input  logic done,
    output logic start
);
    localparam int CNTW = $clog2(GEN_FRAMES + 1);

    typedef enum logic [1:0] {COUNT, KICK, BUSY} state_t;

    state_t state;
    logic [CNTW-1:0] cnt;       // frames since last kick
    logic [CNTW-1:0] cnt_next;

    // saturates at GEN_FRAMES so a kick owed during BUSY is not lost
    always_comb begin
        cnt_next = cnt;
        if (frame && cnt != GEN_FRAMES) begin
            cnt_next = cnt + 1'b1;
        end
        start = (state == KICK);  // one cycle, engine is idle here
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= COUNT;
            cnt <= '0;
        end else begin
            case (state)
                COUNT: begin
                    if (cnt_next == GEN_FRAMES) begin
                        state <= KICK;          // start follows the frame pulse by 1 cycle
                        cnt <= '0;
                    end else begin
                        cnt <= cnt_next;
                    end
                end
                KICK: begin
                    state <= BUSY;
                    cnt <= cnt_next;
                end
                default: begin                  // BUSY, frames keep counting
                    cnt <= cnt_next;
                    if (done) state <= COUNT;
                end
            endcase
        end
    end

endmodule

// ==== hw/life_engine.sv ====
// ----------------------------------------------------------
// life engine: steps the world one cell per cycle and sends
// credit-gated cell updates to the framebuffer
// ----------------------------------------------------------
`timescale 1ns/100ps

module life_engine #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12,
    parameter logic [WIDTH*HEIGHT-1:0] SEED = '0
) (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic start,
    input  logic credit_return,
    output logic wr_valid,
    output logic [$clog2(WIDTH)-1:0] wr_x,
    output logic [$clog2(HEIGHT)-1:0] wr_y,
    output life_pkg::cell_word_t wr_cell,
    output logic done
);
    import life_pkg::*;

    localparam int NCELL = WIDTH * HEIGHT;
    localparam int IDXW = $clog2(NCELL);
    localparam int CRW = $clog2(QDEPTH + 1);

    typedef enum logic [1:0] {IDLE, RUN, FIN} state_t;

    state_t state;
    logic [NCELL-1:0] cur;      // current generation, bit y*WIDTH+x
    logic [NCELL-1:0] nxt;      // generation being built
    logic [IDXW-1:0] idx;       // raster index, tracks wr_x/wr_y
    logic [CRW-1:0] credits;
    logic [3:0] nbrs;           // live neighbours of the current cell
    logic new_alive;
    logic last;

    // cells outside the grid are dead
    function automatic logic cell_at(input logic [NCELL-1:0] w, input int cx, input int cy);
        if (cx < 0 || cx >= WIDTH || cy < 0 || cy >= HEIGHT) begin
            return 1'b0;
        end
        return w[cy * WIDTH + cx];
    endfunction

    always_comb begin
        nbrs = '0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                if (dx != 0 || dy != 0) begin
                    nbrs = nbrs + cell_at(cur, int'(wr_x) + dx, int'(wr_y) + dy);
                end
            end
        end
        new_alive = (nbrs == 4'd3) || (nbrs == 4'd2 && cur[idx]);  // birth 3, survive 2 or 3
        last = (idx == IDXW'(NCELL - 1));
        wr_valid = (state == RUN) && (credits != '0);               // never sent without a credit
        wr_cell.flags.alive = new_alive;
        wr_cell.flags.changed = new_alive ^ cur[idx];
        done = (state == FIN);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            state <= IDLE;
            wr_x <= '0;
            wr_y <= '0;
            idx <= '0;
            credits <= CRW'(QDEPTH);
            cur <= SEED;
        end else begin
            credits <= credits + CRW'(credit_return) - CRW'(wr_valid);
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= RUN;
                        wr_x <= '0;
                        wr_y <= '0;
                        idx <= '0;
                    end
                end
                RUN: begin
                    if (wr_valid) begin             // otherwise hold position for a credit
                        if (last) begin
                            state <= FIN;
                        end else begin
                            idx <= idx + 1'b1;
                            if (wr_x == WIDTH - 1) begin
                                wr_x <= '0;
                                wr_y <= wr_y + 1'b1;
                            end else begin
                                wr_x <= wr_x + 1'b1;
                            end
                        end
                    end
                end
                default: begin                      // FIN, new generation takes over
                    cur <= nxt;
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_pix) begin
        if (wr_valid) nxt[idx] <= new_alive;
    end

endmodule

// ==== hw/framebuffer.sv ====
// ----------------------------------------------------------
// framebuffer: write queue drained in vblank, scaled pixel
// read and palette lookup
// ----------------------------------------------------------
`timescale 1ns/100ps

module framebuffer #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12,
    parameter int SCALE = 2,
    parameter int V_ACTIVE = 24,
    parameter logic [WIDTH*HEIGHT-1:0] SEED = '0
) (
    input  logic clk_pix,
    input  logic rst_n,
    input  logic signed [life_pkg::CORDW-1:0] sx,
    input  logic signed [life_pkg::CORDW-1:0] sy,
    input  logic hsync,
    input  logic vsync,
    input  logic de,
    input  logic wr_valid,
    input  logic [$clog2(WIDTH)-1:0] wr_x,
    input  logic [$clog2(HEIGHT)-1:0] wr_y,
    input  life_pkg::cell_word_t wr_cell,
    output logic credit_return,
    output logic [life_pkg::CHANW-1:0] red,
    output logic [life_pkg::CHANW-1:0] green,
    output logic [life_pkg::CHANW-1:0] blue,
    output logic out_hsync,
    output logic out_vsync,
    output logic out_de
);
    import life_pkg::*;

    localparam int NCELL = WIDTH * HEIGHT;
    localparam int IDXW = $clog2(NCELL);
    localparam int PTRW = $clog2(QDEPTH);

    logic [$clog2(WIDTH)-1:0] q_x [QDEPTH];     // queue payload
    logic [$clog2(HEIGHT)-1:0] q_y [QDEPTH];
    cell_word_t q_cell [QDEPTH];
    logic [PTRW-1:0] wr_ptr, rd_ptr;
    logic [PTRW:0] q_count;
    logic pop;

    cell_word_t mem [NCELL];                    // one word per cell, single port
    cell_word_t rd_word;
    logic [IDXW-1:0] wr_addr, rd_addr;
    logic [11:0] colour;
    logic hsync_p1, vsync_p1, de_p1;

    always_comb begin
        pop = (sy >= V_ACTIVE) && (q_count != '0);  // drain only in vblank
        credit_return = pop;
        wr_addr = IDXW'(int'(q_y[rd_ptr]) * WIDTH + int'(q_x[rd_ptr]));
        rd_addr = IDXW'((sy / SCALE) * WIDTH + sx / SCALE);  // each cell is SCALE x SCALE
        colour = PALETTE[rd_word.cidx];
    end

    // credits guarantee room, so every valid write is taken
    always_ff @(posedge clk_pix) begin
        if (wr_valid) begin
            q_x[wr_ptr] <= wr_x;
            q_y[wr_ptr] <= wr_y;
            q_cell[wr_ptr] <= wr_cell;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
        end else begin
            if (wr_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            q_count <= q_count + (PTRW + 1)'(wr_valid) - (PTRW + 1)'(pop);
        end
    end

    // stage 1: memory, seeded during reset, written in vblank, read in active video
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            for (int i = 0; i < NCELL; i++) begin
                mem[i].cidx <= {1'b0, SEED[i]};
            end
        end else if (pop) begin
            mem[wr_addr] <= q_cell[rd_ptr];
        end else if (de) begin
            rd_word <= mem[rd_addr];
        end
    end

    // stage 2: palette register, syncs delayed to match
    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            {hsync_p1, vsync_p1, de_p1} <= '0;
            {out_hsync, out_vsync, out_de} <= '0;
            {red, green, blue} <= '0;
        end else begin
            {hsync_p1, vsync_p1, de_p1} <= {hsync, vsync, de};
            {out_hsync, out_vsync, out_de} <= {hsync_p1, vsync_p1, de_p1};
            {red, green, blue} <= de_p1 ? colour : 12'h000;  // black in blanking
        end
    end

endmodule

// ==== hw/life_display_top.sv ====
// ----------------------------------------------------------
// life on screen top: timing, scheduler, engine, framebuffer
// ----------------------------------------------------------
`timescale 1ns/100ps

module life_display_top #(
    parameter int WIDTH = 16,
    parameter int HEIGHT = 12,
    parameter int SCALE = 2,
    parameter int GEN_FRAMES = 3,
    parameter logic [WIDTH*HEIGHT-1:0] SEED = 64'h0000_0007_0004_0002,  // glider, top left
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL = 48,
    parameter int V_ACTIVE = 24,
    parameter int V_TOTAL = 40
) (
    input  logic clk_pix,
    input  logic rst_n,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic [life_pkg::CHANW-1:0] red,
    output logic [life_pkg::CHANW-1:0] green,
    output logic [life_pkg::CHANW-1:0] blue,
    output logic frame,
    output logic gen_done
);
    import life_pkg::*;

    logic signed [CORDW-1:0] sx, sy;    // raster position
    logic tim_hsync, tim_vsync, tim_de; // undelayed timing
    logic start;
    logic wr_valid, credit_return;
    logic [$clog2(WIDTH)-1:0] wr_x;
    logic [$clog2(HEIGHT)-1:0] wr_y;
    cell_word_t wr_cell;

    display_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_TOTAL(H_TOTAL),
        .V_ACTIVE(V_ACTIVE),
        .V_TOTAL(V_TOTAL)
    ) i_display_timing (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de),
        .frame, .line()
    );

    gen_scheduler #(
        .GEN_FRAMES(GEN_FRAMES)
    ) i_gen_scheduler (
        .clk_pix, .rst_n, .frame, .done(gen_done), .start
    );

    life_engine #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT),
        .SEED(SEED)
    ) i_life_engine (
        .clk_pix, .rst_n, .start, .credit_return,
        .wr_valid, .wr_x, .wr_y, .wr_cell, .done(gen_done)
    );

    framebuffer #(
        .WIDTH(WIDTH),
        .HEIGHT(HEIGHT),
        .SCALE(SCALE),
        .V_ACTIVE(V_ACTIVE),
        .SEED(SEED)
    ) i_framebuffer (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(tim_hsync), .vsync(tim_vsync), .de(tim_de),
        .wr_valid, .wr_x, .wr_y, .wr_cell, .credit_return,
        .red, .green, .blue,
        .out_hsync(hsync), .out_vsync(vsync), .out_de(de)  // 2 cycles behind sx/sy
    );

endmodule

// ==== sim/tb_clock.sv ====
// ----------------------------------------------------------
// testbench clock and reset source
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_clock #(
    parameter int PERIOD = 100,         // ns
    parameter int RESET_CYCLES = 10
) (
    output logic clk_pix,
    output logic rst_n
);
    initial begin
        clk_pix = 1'b0;
        forever #(PERIOD / 2) clk_pix = ~clk_pix;
    end

    initial begin
        rst_n = 1'b0;                   // held for RESET_CYCLES rising edges
        repeat (RESET_CYCLES) @(posedge clk_pix);
        @(negedge clk_pix);             // released away from the sampling edge
        rst_n = 1'b1;
    end

endmodule

// ==== sim/life_display_sva.sv ====
// ----------------------------------------------------------
// framebuffer protocol checks: credit use, vblank-only drain
// ----------------------------------------------------------
`timescale 1ns/100ps

module life_display_sva #(
    parameter int V_ACTIVE = 24
) (
    input logic clk_pix,
    input logic rst_n,
    input logic signed [life_pkg::CORDW-1:0] sy,
    input logic wr_valid,
    input logic credit_return
);
    import life_pkg::*;

    int outstanding;                    // writes sent, credit not yet back
    int fail_count = 0;                 // read by the testbench top

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(wr_valid) - int'(credit_return);
        end
    end

    // engine credits are QDEPTH minus outstanding
    write_needs_credit: assert property (@(posedge clk_pix) disable iff (!rst_n)
        wr_valid |-> (outstanding < QDEPTH))
        else begin
            fail_count = fail_count + 1;
            $error("write sent while the engine held no credit");
        end

    drain_in_vblank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        credit_return |-> (sy >= V_ACTIVE))
        else begin
            fail_count = fail_count + 1;
            $error("queue drained during active video");
        end

    credits_bounded: assert property (@(posedge clk_pix) disable iff (!rst_n)
        outstanding <= QDEPTH)
        else begin
            fail_count = fail_count + 1;
            $error("more writes outstanding than the queue holds");
        end

endmodule

bind framebuffer life_display_sva #(
    .V_ACTIVE(V_ACTIVE)
) i_life_display_sva (
    .clk_pix(clk_pix),
    .rst_n(rst_n),
    .sy(sy),
    .wr_valid(wr_valid),
    .credit_return(credit_return)
);

// ==== sim/tb_life_display.sv ====
// ----------------------------------------------------------
// life on screen testbench: reference Life model and
// pixel-by-pixel checks of the scaled, paletted output
// ----------------------------------------------------------
`timescale 1ns/100ps

module tb_life_display;
    localparam int WIDTH = 16;
    localparam int HEIGHT = 12;
    localparam int SCALE = 2;
    localparam int GEN_FRAMES = 3;
    localparam int H_ACTIVE = 32;
    localparam int H_TOTAL = 48;
    localparam int V_ACTIVE = 24;
    localparam int V_TOTAL = 40;
    localparam int NCELL = WIDTH * HEIGHT;
    localparam int NUM_GENS = 6;                            // generations shown and compared
    localparam int END_FRAMES = GEN_FRAMES * (NUM_GENS + 1);
    localparam int CYCLE_LIMIT = 8 * GEN_FRAMES * H_TOTAL * V_TOTAL + 2000;

    function automatic logic [NCELL-1:0] cell_mask(input int x, input int y);
        return NCELL'(1) << (y * WIDTH + x);
    endfunction

    // glider top left, blinker mid right, vertical blinker on the right edge
    localparam logic [NCELL-1:0] SEED = cell_mask(1, 0) | cell_mask(2, 1) | cell_mask(0, 2)
        | cell_mask(1, 2) | cell_mask(2, 2) | cell_mask(11, 5) | cell_mask(12, 5)
        | cell_mask(13, 5) | cell_mask(15, 9) | cell_mask(15, 10) | cell_mask(15, 11);

    // birth on 3, survival on 2 or 3, nothing lives outside the grid
    function automatic logic [NCELL-1:0] next_generation(input logic [NCELL-1:0] w);
        logic [NCELL-1:0] n;
        int count;
        n = '0;
        for (int y = 0; y < HEIGHT; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                count = 0;
                for (int ny = y - 1; ny <= y + 1; ny++) begin
                    for (int nx = x - 1; nx <= x + 1; nx++) begin
                        if ((nx != x || ny != y) && nx >= 0 && nx < WIDTH
                            && ny >= 0 && ny < HEIGHT) begin
                            count += int'(w[ny * WIDTH + nx]);
                        end
                    end
                end
                n[y * WIDTH + x] = (count == 3) || (count == 2 && w[y * WIDTH + x]);
            end
        end
        return n;
    endfunction

    function automatic logic [11:0] palette_colour(input logic [1:0] cidx);
        case (cidx)
            2'd0: return 12'h000;                           // dead, black
            2'd1: return 12'h0F0;                           // alive, green
            2'd2: return 12'h600;                           // just died, dim red
            default: return 12'hFFF;                        // just born, white
        endcase
    endfunction

    logic clk_pix, rst_n;
    logic hsync, vsync, de, frame, gen_done;
    logic [3:0] red, green, blue;
    int cycles = 0;
    logic in_reset;                                         // last rising edge was in reset
    int px, py;                                             // mirror of the raster counters
    int x_d1, y_d1, x_d2, y_d2;                             // raster 1 and 2 cycles back
    logic v_d1, v_d2;
    logic [NCELL-1:0] ref_world, ref_next;
    logic [1:0] exp_word [NCELL];                           // word the screen should show
    int frames_since = 0, frame_total = 0, gens_seen = 0;
    int pixel_errors = 0, control_errors = 0, checks = 0;
    int died_pixels = 0, born_pixels = 0;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(10)) i_tb_clock (.clk_pix, .rst_n);

    life_display_top #(
        .WIDTH(WIDTH), .HEIGHT(HEIGHT), .SCALE(SCALE), .GEN_FRAMES(GEN_FRAMES), .SEED(SEED),
        .H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_TOTAL(V_TOTAL)
    ) i_life_display_top (
        .clk_pix, .rst_n, .hsync, .vsync, .de, .red, .green, .blue, .frame, .gen_done
    );

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        in_reset <= !rst_n;
        if (!rst_n) begin
            px <= 0;
            py <= 0;
            v_d1 <= 1'b0;
            v_d2 <= 1'b0;
        end else begin
            px <= (px == H_TOTAL - 1) ? 0 : px + 1;         // wrap at the totals
            if (px == H_TOTAL - 1) py <= (py == V_TOTAL - 1) ? 0 : py + 1;
            x_d1 <= px;
            y_d1 <= py;
            v_d1 <= 1'b1;
            x_d2 <= x_d1;                                   // output lags raster by 2
            y_d2 <= y_d1;
            v_d2 <= v_d1;
        end
    end

    always @(negedge clk_pix) begin : check_outputs
        logic exp_de, exp_hs, exp_vs;
        logic [11:0] exp_rgb;
        int idx;
        if (cycles >= 1) begin
            exp_de = v_d2 && x_d2 < H_ACTIVE && y_d2 < V_ACTIVE;
            exp_hs = v_d2 && x_d2 >= 36 && x_d2 <= 39;
            exp_vs = v_d2 && y_d2 >= 28 && y_d2 <= 29;
            exp_rgb = 12'h000;                              // black outside de
            if (exp_de) begin
                idx = (y_d2 / SCALE) * WIDTH + x_d2 / SCALE; // SCALE x SCALE block per cell
                exp_rgb = palette_colour(exp_word[idx]);
                if ({red, green, blue} == palette_colour(2'd2)) died_pixels++;
                if ({red, green, blue} == palette_colour(2'd3)) born_pixels++;
            end
            checks++;
            assert (de == exp_de && hsync == exp_hs && vsync == exp_vs) else begin
                pixel_errors++;
                $display("[ERROR] %0t: raster (%0d,%0d) de/hs/vs %b%b%b, expected %b%b%b",
                    $time, x_d2, y_d2, de, hsync, vsync, exp_de, exp_hs, exp_vs);
            end
            assert ({red, green, blue} == exp_rgb) else begin
                pixel_errors++;
                $display("[ERROR] %0t: pixel (%0d,%0d) rgb %h, expected %h",
                    $time, x_d2, y_d2, {red, green, blue}, exp_rgb);
            end
            assert (frame == (px == 0 && py == V_ACTIVE)) else begin
                control_errors++;
                $display("[ERROR] %0t: frame %b at raster (%0d,%0d)", $time, frame, px, py);
            end
            if (in_reset) begin
                assert (!frame && !gen_done && !de) else begin
                    control_errors++;
                    $display("[ERROR] %0t: frame/gen_done/de not low in reset", $time);
                end
            end
            if (frame) begin
                frame_total++;
                frames_since++;
                assert (frames_since <= GEN_FRAMES) else begin
                    control_errors++;
                    $display("[ERROR] %0t: %0d frames without gen_done", $time, frames_since);
                end
            end
            if (gen_done) begin
                assert (frames_since == GEN_FRAMES && py >= V_ACTIVE) else begin
                    control_errors++;
                    $display("[ERROR] %0t: gen_done after %0d frames at line %0d",
                        $time, frames_since, py);
                end
                ref_next = next_generation(ref_world);
                for (int i = 0; i < NCELL; i++) begin
                    exp_word[i] = {ref_next[i] ^ ref_world[i], ref_next[i]};  // {changed, alive}
                end
                ref_world = ref_next;
                frames_since = 0;
                gens_seen++;
            end
        end
    end

    initial begin : run_control
        ref_world = SEED;
        for (int i = 0; i < NCELL; i++) begin
            exp_word[i] = {1'b0, SEED[i]};
        end
        wait (frame_total == END_FRAMES || cycles >= CYCLE_LIMIT);
        @(posedge clk_pix);
        assert (gens_seen == NUM_GENS) else begin
            control_errors++;
            $display("[ERROR] %0t: %0d generations seen, expected %0d", $time, gens_seen, NUM_GENS);
        end
        assert (died_pixels > 0 && born_pixels > 0) else begin
            control_errors++;
            $display("[ERROR] %0t: died or born colour never shown", $time);
        end
        if (cycles >= CYCLE_LIMIT) begin
            $display("cycle limit of %0d reached before the last frame was checked", CYCLE_LIMIT);
        end
        $display("checks %0d, pixel errors %0d, control errors %0d, protocol errors %0d",
            checks, pixel_errors, control_errors,
            i_life_display_top.i_framebuffer.i_life_display_sva.fail_count);
        if (cycles < CYCLE_LIMIT && pixel_errors == 0 && control_errors == 0
            && i_life_display_top.i_framebuffer.i_life_display_sva.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/life_pkg.sv
hw/display_timing.sv
hw/gen_scheduler.sv
hw/life_engine.sv
hw/framebuffer.sv
hw/life_display_top.sv
sim/tb_clock.sv
sim/life_display_sva.sv
sim/tb_life_display.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_life_display
FILELIST  = tb.f
BUILD_DIR = obj_dir
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log
PASS_MSG  = all tests passed

SOURCES = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
